//--- verilog/wb_consts.svh
`ifndef WB_CONSTS_SVH
`define WB_CONSTS_SVH

// datapath widths
`define WB_ADDR_W      32
`define WB_RESULT_W    64
`define GPR_W          32
`define GPR_NUM_W      3
`define GPR_COUNT      8

// field widths on the result channel
`define OPSIZE_W       3
`define MSIZE_W        2
`define ALU_OP_W       4

// execute op that swaps its two operands
`define ALU_OP_XCHG    4'd14

// operand size codes from decode
`define OPSIZE_BYTE    3'd0
`define OPSIZE_WORD    3'd1
`define OPSIZE_DWORD   3'd2
`define OPSIZE_QWORD   3'd5

// size codes seen by the data memory write port
`define MSIZE_BYTE     2'd0
`define MSIZE_QWORD    2'd1
`define MSIZE_WORD     2'd2
`define MSIZE_DWORD    2'd3

`endif

//--- verilog/wb_pkg.sv
`include "wb_consts.svh"

package wb_pkg;

   // one execute result word, read whole or as two dwords
   typedef struct packed {
      logic [`GPR_W-1:0] hi;
      logic [`GPR_W-1:0] lo;
   } wb_halves_t;

   // full goes to memory as is
   // lo feeds the primary register write, hi the xchg second write
   typedef union packed {
      logic [`WB_RESULT_W-1:0] full;
      wb_halves_t              halves;
   } wb_result_t;

endpackage

//--- verilog/gpr_file.sv
`timescale 1ns/10ps

`include "wb_consts.svh"

module gpr_file (
   input  logic                  clk,
   input  logic                  arst_n,

   // primary write port, size aware
   input  logic                  wr_en,
   input  logic [`OPSIZE_W-1:0]  wr_size,
   input  logic [`GPR_NUM_W-1:0] wr_num,
   input  logic [`GPR_W-1:0]     wr_data,

   // second write port, always a full dword
   input  logic                  wr2_en,
   input  logic [`GPR_NUM_W-1:0] wr2_num,
   input  logic [`GPR_W-1:0]     wr2_data,

   // read ports
   input  logic [`GPR_NUM_W-1:0] rd_num_a,
   input  logic [`GPR_NUM_W-1:0] rd_num_b,
   output logic [`GPR_W-1:0]     rd_data_a,
   output logic [`GPR_W-1:0]     rd_data_b
);

   logic [`GPR_W-1:0] regs [`GPR_COUNT];
   logic [`GPR_W-1:0] wr_merged;

   // merge the sized write into the old register value
   // upper bits survive a byte or word write
   always_comb begin
      wr_merged = regs[wr_num];
      case (wr_size)
         `OPSIZE_BYTE: begin
            wr_merged[7:0] = wr_data[7:0];
         end
         `OPSIZE_WORD: begin
            wr_merged[15:0] = wr_data[15:0];
         end
         default: begin
            // dword and qword both replace the whole register
            wr_merged = wr_data;
         end
      endcase
   end

   // port 2 is scheduled after port 1 so it wins on the same register
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < `GPR_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else begin
         if (wr_en) begin
            regs[wr_num] <= wr_merged;
         end
         if (wr2_en) begin
            regs[wr2_num] <= wr2_data;
         end
      end
   end

   // combinational reads, no bypass of a write in flight
   assign rd_data_a = regs[rd_num_a];
   assign rd_data_b = regs[rd_num_b];

   // a write strobe from the commit logic must carry a real register number
   a_wr_num_known : assert property (
      @(posedge clk) disable iff (!arst_n)
      wr_en |-> !$isunknown(wr_num)
   ) else begin
      $error("gpr_file: primary write with unknown register number");
   end

   a_wr2_num_known : assert property (
      @(posedge clk) disable iff (!arst_n)
      wr2_en |-> !$isunknown(wr2_num)
   ) else begin
      $error("gpr_file: second write with unknown register number");
   end

endmodule

//--- verilog/wb_reg_commit.sv
`timescale 1ns/10ps

`include "wb_consts.svh"

module wb_reg_commit
   import wb_pkg::*;
(
   // result channel from execute
   input  logic                  wb_valid,
   input  wb_result_t            wb_result,
   input  logic [`GPR_NUM_W-1:0] wb_dest_reg,
   input  logic [`OPSIZE_W-1:0]  wb_opsize,
   input  logic [`ALU_OP_W-1:0]  wb_alu_op,
   input  logic                  wb_op_a_is_reg,
   input  logic                  wb_op_a_is_address,
   input  logic [`GPR_NUM_W-1:0] wb_op_b_reg,
   input  logic                  wb_op_b_is_reg,

   // decode side write strobe
   input  logic                  dec_wb_valid,
   input  logic [`GPR_NUM_W-1:0] dec_wb_reg,
   input  logic [`GPR_W-1:0]     dec_wb_data,
   input  logic [`OPSIZE_W-1:0]  dec_wb_size,

   // from the memory port
   input  logic                  mem_clear,

   output logic                  wb_ready,

   // register file write ports
   output logic                  wr_en,
   output logic [`OPSIZE_W-1:0]  wr_size,
   output logic [`GPR_NUM_W-1:0] wr_num,
   output logic [`GPR_W-1:0]     wr_data,
   output logic                  wr2_en,
   output logic [`GPR_NUM_W-1:0] wr2_num,
   output logic [`GPR_W-1:0]     wr2_data
);

   logic is_xchg;
   logic xchg_to_reg;
   logic reg_bound;
   logic dec_collision;
   logic wb_accept;

   assign is_xchg     = (wb_alu_op == `ALU_OP_XCHG);
   assign xchg_to_reg = is_xchg & wb_op_b_is_reg;

   // result wants either register write port
   assign reg_bound = wb_op_a_is_reg | xchg_to_reg;

   // decode owns port 1 this cycle, so a register-bound result waits
   assign dec_collision = dec_wb_valid & reg_bound;

   assign wb_ready  = mem_clear & ~dec_collision;
   assign wb_accept = wb_valid & wb_ready;

   // port 1 source select, decode first
   assign wr_en   = dec_wb_valid | (wb_accept & wb_op_a_is_reg);
   assign wr_num  = dec_wb_valid ? dec_wb_reg  : wb_dest_reg;
   assign wr_size = dec_wb_valid ? dec_wb_size : wb_opsize;
   assign wr_data = dec_wb_valid ? dec_wb_data : wb_result.halves.lo;

   // xchg puts the old destination value back into operand b
   assign wr2_en   = wb_accept & xchg_to_reg;
   assign wr2_num  = wb_op_b_reg;
   assign wr2_data = wb_result.halves.hi;

   // execute must classify operand a as one kind only
   always_comb begin
      a_op_a_kind : assert #0 (!(wb_valid && wb_op_a_is_reg && wb_op_a_is_address))
      else begin
         $error("wb_reg_commit: operand a flagged as register and address");
      end
   end

endmodule

//--- verilog/wb_mem_port.sv
`timescale 1ns/10ps

`include "wb_consts.svh"

module wb_mem_port
   import wb_pkg::*;
(
   // result channel from execute
   input  logic                    wb_valid,
   input  logic                    wb_ready,
   input  wb_result_t              wb_result,
   input  logic [`WB_ADDR_W-1:0]   wb_dest_address,
   input  logic [`OPSIZE_W-1:0]    wb_opsize,
   input  logic [`ALU_OP_W-1:0]    wb_alu_op,
   input  logic                    wb_op_a_is_address,
   input  logic [`WB_ADDR_W-1:0]   wb_op_b_address,
   input  logic                    wb_op_b_is_address,

   input  logic                    wmem_ready,

   // to the commit logic
   output logic                    mem_clear,

   // data memory write port
   output logic                    wmem_valid,
   output logic [`WB_ADDR_W-1:0]   wmem_address,
   output logic                    wmem_wr_en,
   output logic [`WB_RESULT_W-1:0] wmem_wr_data,
   output logic [`MSIZE_W-1:0]     wmem_wr_size
);

   logic is_xchg;
   logic xchg_to_mem;
   logic mem_needed;
   logic [`WB_RESULT_W-1:0] hi_zext;

   assign is_xchg = (wb_alu_op == `ALU_OP_XCHG);

   // xchg with a memory operand b writes the swapped half there
   assign xchg_to_mem = is_xchg & wb_op_b_is_address;
   assign mem_needed  = xchg_to_mem | wb_op_a_is_address;

   assign hi_zext = {{(`WB_RESULT_W - `GPR_W){1'b0}}, wb_result.halves.hi};

   // address and data steering
   assign wmem_address = xchg_to_mem ? wb_op_b_address : wb_dest_address;
   assign wmem_wr_data = xchg_to_mem ? hi_zext : wb_result.full;
   assign wmem_wr_en   = mem_needed;

   // nothing to store, or memory can take it now
   assign mem_clear = ~mem_needed | wmem_ready;

   // one pulse per accepted store
   assign wmem_valid = wb_valid & wb_ready & mem_needed;

   // operand size to memory size code
   always_comb begin
      case (wb_opsize)
         `OPSIZE_BYTE: begin
            wmem_wr_size = `MSIZE_BYTE;
         end
         `OPSIZE_WORD: begin
            wmem_wr_size = `MSIZE_WORD;
         end
         `OPSIZE_DWORD: begin
            wmem_wr_size = `MSIZE_DWORD;
         end
         `OPSIZE_QWORD: begin
            wmem_wr_size = `MSIZE_QWORD;
         end
         default: begin
            wmem_wr_size = `MSIZE_BYTE;
         end
      endcase
   end

   // commit side must hold a store back while memory is busy
   always_comb begin
      a_wmem_handshake : assert #0 (!wmem_valid || wmem_ready)
      else begin
         $error("wb_mem_port: memory write issued without ready");
      end
   end

endmodule

//--- verilog/wb_top.sv
`timescale 1ns/10ps

`include "wb_consts.svh"

module wb_top
   import wb_pkg::*;
(
   input  logic                    clk,
   input  logic                    arst_n,

   // result channel from execute
   input  logic                    wb_valid,
   output logic                    wb_ready,
   input  wb_result_t              wb_result,
   input  logic [`GPR_NUM_W-1:0]   wb_dest_reg,
   input  logic [`WB_ADDR_W-1:0]   wb_dest_address,
   input  logic [`OPSIZE_W-1:0]    wb_opsize,
   input  logic [`ALU_OP_W-1:0]    wb_alu_op,
   input  logic                    wb_op_a_is_reg,
   input  logic                    wb_op_a_is_address,
   input  logic [`GPR_NUM_W-1:0]   wb_op_b_reg,
   input  logic                    wb_op_b_is_reg,
   input  logic [`WB_ADDR_W-1:0]   wb_op_b_address,
   input  logic                    wb_op_b_is_address,

   // decode side register write
   input  logic                    dec_wb_valid,
   input  logic [`GPR_NUM_W-1:0]   dec_wb_reg,
   input  logic [`GPR_W-1:0]       dec_wb_data,
   input  logic [`OPSIZE_W-1:0]    dec_wb_size,

   // data memory write port
   output logic                    wmem_valid,
   input  logic                    wmem_ready,
   output logic [`WB_ADDR_W-1:0]   wmem_address,
   output logic                    wmem_wr_en,
   output logic [`WB_RESULT_W-1:0] wmem_wr_data,
   output logic [`MSIZE_W-1:0]     wmem_wr_size,

   // register read ports
   input  logic [`GPR_NUM_W-1:0]   rd_num_a,
   input  logic [`GPR_NUM_W-1:0]   rd_num_b,
   output logic [`GPR_W-1:0]       rd_data_a,
   output logic [`GPR_W-1:0]       rd_data_b
);

   logic                  mem_clear;
   logic                  wr_en;
   logic [`OPSIZE_W-1:0]  wr_size;
   logic [`GPR_NUM_W-1:0] wr_num;
   logic [`GPR_W-1:0]     wr_data;
   logic                  wr2_en;
   logic [`GPR_NUM_W-1:0] wr2_num;
   logic [`GPR_W-1:0]     wr2_data;

   wb_reg_commit u_reg_commit (
      .wb_valid           (wb_valid),
      .wb_result          (wb_result),
      .wb_dest_reg        (wb_dest_reg),
      .wb_opsize          (wb_opsize),
      .wb_alu_op          (wb_alu_op),
      .wb_op_a_is_reg     (wb_op_a_is_reg),
      .wb_op_a_is_address (wb_op_a_is_address),
      .wb_op_b_reg        (wb_op_b_reg),
      .wb_op_b_is_reg     (wb_op_b_is_reg),
      .dec_wb_valid       (dec_wb_valid),
      .dec_wb_reg         (dec_wb_reg),
      .dec_wb_data        (dec_wb_data),
      .dec_wb_size        (dec_wb_size),
      .mem_clear          (mem_clear),
      .wb_ready           (wb_ready),
      .wr_en              (wr_en),
      .wr_size            (wr_size),
      .wr_num             (wr_num),
      .wr_data            (wr_data),
      .wr2_en             (wr2_en),
      .wr2_num            (wr2_num),
      .wr2_data           (wr2_data)
   );

   wb_mem_port u_mem_port (
      .wb_valid           (wb_valid),
      .wb_ready           (wb_ready),
      .wb_result          (wb_result),
      .wb_dest_address    (wb_dest_address),
      .wb_opsize          (wb_opsize),
      .wb_alu_op          (wb_alu_op),
      .wb_op_a_is_address (wb_op_a_is_address),
      .wb_op_b_address    (wb_op_b_address),
      .wb_op_b_is_address (wb_op_b_is_address),
      .wmem_ready         (wmem_ready),
      .mem_clear          (mem_clear),
      .wmem_valid         (wmem_valid),
      .wmem_address       (wmem_address),
      .wmem_wr_en         (wmem_wr_en),
      .wmem_wr_data       (wmem_wr_data),
      .wmem_wr_size       (wmem_wr_size)
   );

   gpr_file u_gpr_file (
      .clk       (clk),
      .arst_n    (arst_n),
      .wr_en     (wr_en),
      .wr_size   (wr_size),
      .wr_num    (wr_num),
      .wr_data   (wr_data),
      .wr2_en    (wr2_en),
      .wr2_num   (wr2_num),
      .wr2_data  (wr2_data),
      .rd_num_a  (rd_num_a),
      .rd_num_b  (rd_num_b),
      .rd_data_a (rd_data_a),
      .rd_data_b (rd_data_b)
   );

endmodule

//--- verif/wb_tb.sv
`timescale 1ns/10ps

`include "wb_consts.svh"

module wb_tb
   import wb_pkg::*;
;

   localparam int RESET_CYCLES = 5;
   localparam int MAX_STALL    = 6;
   localparam int N_REG        = 40;
   localparam int N_XCHG       = 20;
   localparam int N_STORE      = 30;
   localparam int N_STALL      = 20;
   localparam int N_DEC        = 20;
   localparam int N_OPS        = N_REG + N_XCHG + N_STORE + N_STALL + N_DEC;
   // six register sweeps of eight cycles each, plus slack
   localparam int STIM_CYCLES  = RESET_CYCLES + 6 * 8 + N_OPS * (MAX_STALL + 2) + 10;
   localparam int WATCHDOG_NS  = STIM_CYCLES * 20 * 2;

   logic                    clk;
   logic                    arst_n;
   logic                    wb_valid;
   logic                    wb_ready;
   wb_result_t              wb_result;
   logic [`GPR_NUM_W-1:0]   wb_dest_reg;
   logic [`WB_ADDR_W-1:0]   wb_dest_address;
   logic [`OPSIZE_W-1:0]    wb_opsize;
   logic [`ALU_OP_W-1:0]    wb_alu_op;
   logic                    wb_op_a_is_reg;
   logic                    wb_op_a_is_address;
   logic [`GPR_NUM_W-1:0]   wb_op_b_reg;
   logic                    wb_op_b_is_reg;
   logic [`WB_ADDR_W-1:0]   wb_op_b_address;
   logic                    wb_op_b_is_address;
   logic                    dec_wb_valid;
   logic [`GPR_NUM_W-1:0]   dec_wb_reg;
   logic [`GPR_W-1:0]       dec_wb_data;
   logic [`OPSIZE_W-1:0]    dec_wb_size;
   logic                    wmem_valid;
   logic                    wmem_ready;
   logic [`WB_ADDR_W-1:0]   wmem_address;
   logic                    wmem_wr_en;
   logic [`WB_RESULT_W-1:0] wmem_wr_data;
   logic [`MSIZE_W-1:0]     wmem_wr_size;
   logic [`GPR_NUM_W-1:0]   rd_num_a;
   logic [`GPR_NUM_W-1:0]   rd_num_b;
   logic [`GPR_W-1:0]       rd_data_a;
   logic [`GPR_W-1:0]       rd_data_b;

   integer            seed;
   int                err_count;
   int                check_count;
   int                mem_pulses;
   string             test_name;
   logic [`GPR_W-1:0] model [`GPR_COUNT];

   wb_top u_dut (.*);

   always #10 clk = ~clk;

   task automatic check_value(input string what, input logic [63:0] expected,
                              input logic [63:0] actual);
      check_count++;
      if (actual !== expected) begin
         err_count++;
         $display("ERROR %s %s at %0t: expected %h actual %h",
                  test_name, what, $time, expected, actual);
      end
   endtask

   // sized register write as x86 defines it, upper bits kept
   function automatic logic [31:0] sized_merge(input logic [31:0] old, input logic [2:0] size,
                                               input logic [31:0] data);
      case (size)
         `OPSIZE_BYTE: return {old[31:8], data[7:0]};
         `OPSIZE_WORD: return {old[31:16], data[15:0]};
         default:      return data;
      endcase
   endfunction

   // {needed, address, data, size code} of the memory write for a result
   function automatic logic [98:0] expected_mem(input wb_result_t res,
                                                input logic [31:0] dest_addr,
                                                input logic [2:0] opsize,
                                                input logic [3:0] op,
                                                input logic a_is_addr,
                                                input logic [31:0] b_addr,
                                                input logic b_is_addr);
      logic       xchg_mem;
      logic [1:0] msize;
      xchg_mem = (op == 4'd14) && b_is_addr;
      case (opsize)
         3'd0:    msize = 2'd0;
         3'd1:    msize = 2'd2;
         3'd2:    msize = 2'd3;
         3'd5:    msize = 2'd1;
         default: msize = 2'd0;
      endcase
      if (xchg_mem) begin
         return {1'b1, b_addr, {32'h0, res.halves.hi}, msize};
      end
      return {a_is_addr, dest_addr, res.full, msize};
   endfunction

   always @(posedge clk) begin : compare
      logic [98:0] mem_exp;
      logic        need;
      logic        reg_bound;
      logic        ready_exp;
      logic        accept;
      logic        is_xchg;
      if (arst_n) begin
         mem_exp = expected_mem(wb_result, wb_dest_address, wb_opsize, wb_alu_op,
                                wb_op_a_is_address, wb_op_b_address, wb_op_b_is_address);
         need      = mem_exp[98];
         is_xchg   = (wb_alu_op == 4'd14);
         reg_bound = wb_op_a_is_reg | (is_xchg & wb_op_b_is_reg);
         ready_exp = (!need | wmem_ready) & !(dec_wb_valid & reg_bound);
         accept    = wb_valid & ready_exp;
         check_value("wb_ready", ready_exp, wb_ready);
         check_value("wmem_valid", accept & need & wmem_ready, wmem_valid);
         if (accept) begin
            check_value("wmem_wr_en", need, wmem_wr_en);
         end
         if (accept && need) begin
            check_value("wmem_address", mem_exp[97:66], wmem_address);
            check_value("wmem_wr_data", mem_exp[65:2], wmem_wr_data);
            check_value("wmem_wr_size", mem_exp[1:0], wmem_wr_size);
         end
         if (wmem_valid === 1'b1) begin
            mem_pulses++;
         end
         check_value("rd_data_a", model[rd_num_a], rd_data_a);
         check_value("rd_data_b", model[rd_num_b], rd_data_b);
         // port 1 first, then the xchg second write on top of it
         if (dec_wb_valid) begin
            model[dec_wb_reg] = sized_merge(model[dec_wb_reg], dec_wb_size, dec_wb_data);
         end else if (accept && wb_op_a_is_reg) begin
            model[wb_dest_reg] = sized_merge(model[wb_dest_reg], wb_opsize,
                                             wb_result.halves.lo);
         end
         if (accept && is_xchg && wb_op_b_is_reg) begin
            model[wb_op_b_reg] = wb_result.halves.hi;
         end
      end
   end

   function automatic logic [2:0] pick_size();
      case ($random(seed) & 32'd3)
         0:       return `OPSIZE_BYTE;
         1:       return `OPSIZE_WORD;
         2:       return `OPSIZE_DWORD;
         default: return `OPSIZE_QWORD;
      endcase
   endfunction

   // kind 0 register op, 1 xchg reg/reg, 2 plain store, 3 xchg reg/mem
   task automatic load_result(input int kind);
      wb_result.full     = {$random(seed), $random(seed)};
      wb_dest_reg        = $random(seed);
      wb_dest_address    = $random(seed);
      wb_op_b_reg        = $random(seed);
      wb_op_b_address    = $random(seed);
      wb_opsize          = pick_size();
      wb_alu_op          = $random(seed);
      if (wb_alu_op == `ALU_OP_XCHG) begin
         wb_alu_op = 4'd0;
      end
      wb_op_a_is_reg     = (kind != 2);
      wb_op_a_is_address = (kind == 2);
      wb_op_b_is_reg     = (kind == 1);
      wb_op_b_is_address = (kind == 3);
      if (kind == 1 || kind == 3) begin
         wb_alu_op = `ALU_OP_XCHG;
      end
      if (kind == 2) begin
         // stores also see the unmapped size codes
         wb_opsize = $random(seed);
      end
   endtask

   // called and left on a falling edge
   task automatic present_result(input int stall, input logic with_dec);
      int   pulses_before;
      int   waited;
      logic accepted;
      logic need;
      pulses_before = mem_pulses;
      need = wb_op_a_is_address | ((wb_alu_op == 4'd14) & wb_op_b_is_address);
      wb_valid   = 1'b1;
      wmem_ready = (stall == 0);
      rd_num_a   = wb_dest_reg;
      rd_num_b   = wb_op_b_reg;
      if (with_dec) begin
         dec_wb_valid = 1'b1;
         dec_wb_reg   = $random(seed);
         dec_wb_data  = $random(seed);
         dec_wb_size  = pick_size();
      end
      waited   = 0;
      accepted = 1'b0;
      while (!accepted) begin
         @(posedge clk);
         accepted = wb_valid && wb_ready;
         @(negedge clk);
         dec_wb_valid = 1'b0;
         waited++;
         wmem_ready = (waited >= stall);
      end
      wb_valid   = 1'b0;
      wmem_ready = 1'b1;
      check_value("wmem_valid pulses", need ? 1 : 0, mem_pulses - pulses_before);
   endtask

   task automatic sweep_regs();
      for (int i = 0; i < `GPR_COUNT; i++) begin
         rd_num_a = i;
         rd_num_b = `GPR_COUNT - 1 - i;
         @(negedge clk);
      end
   endtask

   initial begin
      seed = 32'haaf48ea2;
      err_count = 0;
      check_count = 0;
      mem_pulses = 0;
      test_name = "reset";
      for (int i = 0; i < `GPR_COUNT; i++) begin
         model[i] = '0;
      end
      clk = 1'b0;
      arst_n = 1'b0;
      wb_valid = 1'b0;
      wb_result = '0;
      wb_dest_reg = '0;
      wb_dest_address = '0;
      wb_opsize = '0;
      wb_alu_op = '0;
      wb_op_a_is_reg = 1'b0;
      wb_op_a_is_address = 1'b0;
      wb_op_b_reg = '0;
      wb_op_b_is_reg = 1'b0;
      wb_op_b_address = '0;
      wb_op_b_is_address = 1'b0;
      dec_wb_valid = 1'b0;
      dec_wb_reg = '0;
      dec_wb_data = '0;
      dec_wb_size = '0;
      wmem_ready = 1'b1;
      rd_num_a = '0;
      rd_num_b = '0;
      repeat (RESET_CYCLES) @(negedge clk);
      arst_n = 1'b1;
      sweep_regs();

      test_name = "reg_write";
      repeat (N_REG) begin
         load_result(0);
         present_result(0, 1'b0);
      end
      sweep_regs();

      test_name = "xchg_reg";
      for (int i = 0; i < N_XCHG; i++) begin
         load_result(1);
         if (i % 4 == 0) begin
            wb_op_b_reg = wb_dest_reg;
         end
         present_result(0, 1'b0);
      end
      sweep_regs();

      test_name = "mem_store";
      for (int i = 0; i < N_STORE; i++) begin
         load_result((i % 2 == 0) ? 2 : 3);
         present_result(0, 1'b0);
      end
      sweep_regs();

      test_name = "mem_stall";
      for (int i = 0; i < N_STALL; i++) begin
         load_result((i % 2 == 0) ? 3 : 2);
         present_result(1 + (($random(seed) & 32'h7fff_ffff) % MAX_STALL), 1'b0);
      end
      sweep_regs();

      // decode strobe lands on the same cycle as a register-bound result
      test_name = "dec_collide";
      for (int i = 0; i < N_DEC; i++) begin
         load_result(i % 2);
         present_result(0, 1'b1);
      end
      sweep_regs();

      $display("checks %0d, errors %0d", check_count, err_count);
      if (err_count == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("run timed out after %0d ns, a result was never accepted", WATCHDOG_NS);
      $display("tests failed");
      $finish;
   end

endmodule

//--- sim.f
+incdir+verilog
verilog/wb_pkg.sv
verilog/gpr_file.sv
verilog/wb_reg_commit.sv
verilog/wb_mem_port.sv
verilog/wb_top.sv
verif/wb_tb.sv
